//--- Makefile
VERILATOR ?= verilator
TOP ?= tbMips
FILELIST ?= all.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- all.f
isaPkg.sv
corePkg.sv
control.sv
alu.sv
regFile.sv
pcUnit.sv
dataPort.sv
mipsCore.sv
tbMips_sva.sv
tbMips.sv

//--- alu.sv
`timescale 1ns/10ps

module alu
	import isaPkg::*, corePkg::*;
(
	input aluOp_e op,
	input word_t a,
	input word_t b,
	output word_t y,
	output logic zero
);

	always_comb begin
		case (op)
			corePkg::ADD: y = a + b;
			corePkg::SUB: y = a - b;
			corePkg::SLT: y = {31'd0, $signed(a) < $signed(b)}; // signed compare
			XOR: y = a ^ b;
			default: y = '0; // NOP
		endcase
	end

	assign zero = (y == '0); // bne takes the branch when low

endmodule

//--- control.sv
`timescale 1ns/10ps

module control
	import isaPkg::*, corePkg::*;
(
	input instr_t instr,
	output ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // undefined codes fall through as a nop
		case (instr.op)
			R_TYPE: begin
				ctrl.regDst = RD;
				case (instr.lo.rFmt.funct)
					isaPkg::JR: begin
						ctrl.jump = REG; // no write back
					end
					isaPkg::ADD: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = corePkg::ADD;
					end
					isaPkg::SUB: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = corePkg::SUB;
					end
					isaPkg::SLT: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = corePkg::SLT;
					end
					default: ctrl = '0; // unknown funct
				endcase
			end
			XORI: begin
				ctrl.regDst = RT;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1; // zero-extended in the core
				ctrl.aluOp = XOR;
			end
			BNE: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = corePkg::SUB; // compare rs and rt
			end
			J: begin
				ctrl.jump = TARGET;
			end
			JAL: begin
				ctrl.regDst = RA;
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = LINK;
				ctrl.jump = TARGET;
			end
			LW: begin
				ctrl.regDst = RT;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = MEM;
				ctrl.aluOp = corePkg::ADD; // base + offset
			end
			SW: begin
				ctrl.regDst = RT;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = corePkg::ADD;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- corePkg.sv
package corePkg;

	typedef enum logic [2:0] {
		NOP = 3'b000,
		ADD = 3'b001,
		SUB = 3'b010,
		SLT = 3'b011,
		XOR = 3'b100
	} aluOp_e;

	typedef enum logic [1:0] {
		RD = 2'b00, // R-type destination
		RT = 2'b01, // I-type destination
		RA = 2'b10  // jal link register
	} regDst_e;

	typedef enum logic [1:0] {
		ALU  = 2'b00,
		MEM  = 2'b01,
		LINK = 2'b10 // pc + 4 for jal
	} memToReg_e;

	typedef enum logic [1:0] {
		NONE   = 2'b00,
		TARGET = 2'b01, // j, jal
		REG    = 2'b10  // jr
	} jump_e;

	typedef struct packed {
		regDst_e regDst;
		logic regWrite;
		logic aluSrc;     // immediate as ALU operand b
		logic memWrite;
		logic memRead;
		memToReg_e memToReg;
		logic branch;     // bne, taken when the ALU result is nonzero
		jump_e jump;
		aluOp_e aluOp;
	} ctrl_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		isaPkg::word_t adr;
		isaPkg::word_t datW;
	} wbMaster_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic ack;
		isaPkg::word_t datR;
	} wbSlave_t;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		BUSY = 2'b01, // bus cycle open, waiting for ack
		DONE = 2'b10
	} portState_e;

endpackage

//--- dataPort.sv
`timescale 1ns/10ps

module dataPort
	import isaPkg::*, corePkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrl_t ctrl,
	input word_t addr,
	input word_t storeData,
	output wbMaster_t wbOut,
	input wbSlave_t wbIn,
	output logic stall,
	output word_t loadData
);

	portState_e state;
	logic memOp;

	assign memOp = ctrl.memRead | ctrl.memWrite;
	assign stall = memOp && (state != DONE); // released for the commit cycle

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			wbOut <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (memOp) begin
						state <= BUSY;
						wbOut.cyc <= 1'b1;
						wbOut.stb <= 1'b1;
						wbOut.we <= ctrl.memWrite;
						wbOut.adr <= addr; // held until ack
						wbOut.datW <= storeData;
					end
				end
				BUSY: begin
					if (wbIn.ack) begin
						state <= DONE;
						wbOut.cyc <= 1'b0;
						wbOut.stb <= 1'b0;
					end
				end
				default: state <= IDLE; // DONE lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == BUSY && wbIn.ack) begin
			loadData <= wbIn.datR; // lw result
		end
	end

endmodule

//--- isaPkg.sv
package isaPkg;

	typedef logic [31:0] word_t;        // data and address word
	typedef logic [4:0] regIdx_t;       // register index

	localparam regIdx_t RA_REG = 5'd31; // link register written by jal

	typedef enum logic [5:0] {
		R_TYPE = 6'b000000, // add, sub, slt, jr
		XORI   = 6'b001110,
		BNE    = 6'b000101,
		J      = 6'b000010,
		JAL    = 6'b000011,
		LW     = 6'b100011,
		SW     = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		JR  = 6'b001000,
		ADD = 6'b100000,
		SUB = 6'b100010,
		SLT = 6'b101010
	} funct_e;

	// lower half of the word, read as R-type fields or as the immediate
	typedef struct packed {
		regIdx_t rd;
		logic [4:0] shamt;
		funct_e funct;
	} rFields_t;

	typedef union packed {
		rFields_t rFmt;   // R-type view
		logic [15:0] imm; // I-type view
	} lowHalf_t;

	typedef struct packed {
		opcode_e op;
		regIdx_t rs;
		regIdx_t rt;
		lowHalf_t lo; // rs, rt and lo together form the 26-bit jump target
	} instr_t;

endpackage

//--- mipsCore.sv
`timescale 1ns/10ps

module mipsCore
	import isaPkg::*, corePkg::*;
(
	input logic clk,
	input logic rstN,
	output word_t imemAddr,
	input instr_t imemData,
	output wbMaster_t wbOut,
	input wbSlave_t wbIn
);

	ctrl_t ctrl;
	word_t pc, pcPlus4;
	word_t rDataA, rDataB;
	word_t aluB, aluY, wData, loadData;
	regIdx_t wAddr;
	logic zero, stall;

	assign imemAddr = pc;

	control uCtrl (.instr(imemData), .ctrl(ctrl));

	always_comb begin
		case (ctrl.regDst)
			RT: wAddr = imemData.rt;
			RA: wAddr = RA_REG;
			default: wAddr = imemData.lo.rFmt.rd;
		endcase
	end

	always_comb begin
		if (!ctrl.aluSrc) begin
			aluB = rDataB;
		end else if (imemData.op == XORI) begin
			aluB = {16'd0, imemData.lo.imm}; // logical immediate
		end else begin
			aluB = {{16{imemData.lo.imm[15]}}, imemData.lo.imm}; // lw, sw offset
		end
	end

	always_comb begin
		case (ctrl.memToReg)
			MEM: wData = loadData;
			LINK: wData = pcPlus4;
			default: wData = aluY;
		endcase
	end

	regFile uRegs (
		.clk(clk), .rstN(rstN),
		.rAddrA(imemData.rs), .rAddrB(imemData.rt),
		.rDataA(rDataA), .rDataB(rDataB),
		.we(ctrl.regWrite && !stall), // commit only once the op completes
		.wAddr(wAddr), .wData(wData)
	);

	alu uAlu (.op(ctrl.aluOp), .a(rDataA), .b(aluB), .y(aluY), .zero(zero));

	pcUnit uPc (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .stall(stall), .zero(zero),
		.imm(imemData.lo.imm),
		.target({imemData.rs, imemData.rt, imemData.lo}),
		.rsData(rDataA), .pc(pc), .pcPlus4(pcPlus4)
	);

	dataPort uData (
		.clk(clk), .rstN(rstN), .ctrl(ctrl),
		.addr(aluY), .storeData(rDataB),
		.wbOut(wbOut), .wbIn(wbIn),
		.stall(stall), .loadData(loadData)
	);

endmodule

//--- pcUnit.sv
`timescale 1ns/10ps

module pcUnit
	import isaPkg::*, corePkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrl_t ctrl,
	input logic stall,
	input logic zero,
	input logic [15:0] imm,
	input logic [25:0] target,
	input word_t rsData,
	output word_t pc,
	output word_t pcPlus4
);

	word_t nextPc;
	word_t branchOff;

	assign pcPlus4 = pc + 32'd4;
	assign branchOff = {{14{imm[15]}}, imm, 2'b00}; // sign-extended word offset

	always_comb begin
		case (ctrl.jump)
			TARGET: nextPc = {pcPlus4[31:28], target, 2'b00};
			REG: nextPc = rsData; // jr
			default: begin
				if (ctrl.branch && !zero) begin
					nextPc = pcPlus4 + branchOff; // bne taken
				end else begin
					nextPc = pcPlus4;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (!stall) begin // hold during memory ops
			pc <= nextPc;
		end
	end

endmodule

//--- regFile.sv
`timescale 1ns/10ps

module regFile
	import isaPkg::*;
(
	input logic clk,
	input logic rstN,
	input regIdx_t rAddrA,
	input regIdx_t rAddrB,
	output word_t rDataA,
	output word_t rDataB,
	input logic we,
	input regIdx_t wAddr,
	input word_t wData
);

	word_t regs [32];

	// register zero never gets written, so it reads as zero
	assign rDataA = regs[rAddrA];
	assign rDataB = regs[rAddrB];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wAddr != '0)) begin
			regs[wAddr] <= wData;
		end
	end

endmodule

//--- tbMips.sv
`timescale 1ns/10ps

module tbMips
	import isaPkg::*, corePkg::*;
();

	logic clk = 1'b0;
	logic rstN = 1'b0;
	word_t imemAddr;
	instr_t imemData;
	wbMaster_t wbOut;
	wbSlave_t wbIn = '0;

	instr_t rom [64];
	word_t slaveMem [64];
	wbMaster_t expQ [$]; // transfers still expected in order
	word_t pcQ [$];      // expected fetch path
	word_t trace [$];    // fetch path seen with repeats folded
	string curTest = "";
	logic inXfer = 1'b0;
	logic [1:0] waitLeft = 2'd0;
	logic [31:0] lcgState = 32'd17536;

	mipsCore UUT (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.wbOut(wbOut), .wbIn(wbIn)
	);

	assign imemData = rom[imemAddr[7:2]]; // combinational ROM

	always #4 clk = ~clk;

	function automatic instr_t rIns(logic [5:0] f, regIdx_t rs, regIdx_t rt, regIdx_t rd);
		return instr_t'({6'd0, rs, rt, rd, 5'd0, f});
	endfunction

	function automatic instr_t iIns(logic [5:0] op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
		return instr_t'({op, rs, rt, imm});
	endfunction

	function automatic instr_t jIns(logic [5:0] op, word_t dest);
		return instr_t'({op, dest[27:2]});
	endfunction

	function automatic wbMaster_t busOp(logic we, word_t adr, word_t dat);
		return wbMaster_t'({1'b1, 1'b1, we, adr, dat});
	endfunction

	function automatic logic [1:0] nextDelay();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[17:16]; // 0 to 3 wait cycles
	endfunction

	task automatic stopFail(string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkBus(string name, wbMaster_t want, wbMaster_t got);
		// datW only carries meaning on writes
		if (got.we !== want.we || got.adr !== want.adr
			|| (want.we && got.datW !== want.datW)) begin
			stopFail($sformatf("error %s: expected we=%0b adr=%h datW=%h, actual we=%0b adr=%h datW=%h",
				name, want.we, want.adr, want.datW, got.we, got.adr, got.datW));
		end
	endtask

	task automatic checkFetch(string name, word_t want, word_t got);
		if (got !== want) begin
			stopFail($sformatf("error %s: expected fetch address %h, actual %h", name, want, got));
		end
	endtask

	task automatic serveBus();
		wbMaster_t want;
		if (expQ.size() == 0) begin
			stopFail($sformatf("%s: the core started a bus transfer that was not expected",
				curTest));
		end
		want = expQ.pop_front();
		checkBus(curTest, want, wbOut);
		if (wbOut.we) begin
			slaveMem[wbOut.adr[7:2]] = wbOut.datW;
		end else begin
			wbIn.datR = slaveMem[wbOut.adr[7:2]];
		end
		wbIn.ack = 1'b1;
		inXfer = 1'b0;
	endtask

	// Wishbone slave with random wait states
	always @(negedge clk) begin
		if (!wbOut.cyc) begin
			wbIn.ack = 1'b0;
			inXfer = 1'b0;
		end else if (!wbIn.ack) begin
			if (!inXfer) begin
				inXfer = 1'b1;
				waitLeft = nextDelay();
			end
			if (waitLeft != 2'd0) begin
				waitLeft = waitLeft - 2'd1;
			end else begin
				serveBus();
			end
		end
	end

	always @(negedge clk) begin
		if (trace.size() == 0 || imemAddr != trace[$]) begin
			trace.push_back(imemAddr);
		end
	end

	task automatic pathRange(word_t from, word_t upTo);
		for (word_t a = from; a <= upTo; a += 32'd4) begin
			pcQ.push_back(a);
		end
	endtask

	task automatic holdReset(string name);
		@(negedge clk);
		rstN = 1'b0;
		curTest = name;
		for (int i = 0; i < 64; i++) begin
			rom[i] = jIns(J, word_t'(i * 4)); // unused slots spin in place
		end
		expQ.delete();
		pcQ.delete();
	endtask

	task automatic runProgram();
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		trace.delete();
		trace.push_back(imemAddr);
		while (expQ.size() != 0 || trace.size() < pcQ.size()) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk); // a stray jump would show up here
		if (trace.size() != pcQ.size()) begin
			stopFail($sformatf("%s: the core fetched %0d addresses where %0d were expected",
				curTest, trace.size(), pcQ.size()));
		end
		foreach (pcQ[i]) begin
			checkFetch(curTest, pcQ[i], trace[i]);
		end
	endtask

	task automatic resetValues();
		holdReset("reset");
		pathRange(32'd0, 32'd0);
		runProgram();
		checkFetch(curTest, 32'd0, imemAddr);
		if (wbOut.cyc !== 1'b0) begin
			stopFail("reset: the bus cycle is open after reset");
		end
	endtask

	task automatic arithOps();
		word_t a = 32'h1234;
		word_t b = 32'h00ff;
		word_t neg = 32'd0 - a;
		holdReset("arith");
		rom[0] = iIns(XORI, 5'd0, 5'd1, 16'h1234);
		rom[1] = iIns(XORI, 5'd0, 5'd2, 16'h00ff);
		rom[2] = rIns(isaPkg::ADD, 5'd1, 5'd2, 5'd3);
		rom[3] = rIns(isaPkg::SUB, 5'd0, 5'd1, 5'd4);
		rom[4] = rIns(isaPkg::SUB, 5'd1, 5'd2, 5'd5);
		rom[5] = rIns(isaPkg::SLT, 5'd4, 5'd2, 5'd6); // negative < positive
		rom[6] = rIns(isaPkg::SLT, 5'd2, 5'd4, 5'd7);
		rom[7] = iIns(XORI, 5'd1, 5'd8, 16'hffff);
		for (int i = 0; i < 6; i++) begin
			rom[8 + i] = iIns(SW, 5'd0, regIdx_t'(3 + i), 16'(4 * i));
		end
		expQ.push_back(busOp(1'b1, 32'h00, a + b));
		expQ.push_back(busOp(1'b1, 32'h04, neg));
		expQ.push_back(busOp(1'b1, 32'h08, a - b));
		expQ.push_back(busOp(1'b1, 32'h0c, 32'd1)); // neg lies below b
		expQ.push_back(busOp(1'b1, 32'h10, 32'd0));
		expQ.push_back(busOp(1'b1, 32'h14, a ^ 32'h0000ffff));
		pathRange(32'd0, 32'd56);
		runProgram();
	endtask

	task automatic loadStoreWaits();
		holdReset("loadStore");
		rom[0] = iIns(XORI, 5'd0, 5'd1, 16'h5a5a);
		rom[1] = iIns(SW, 5'd0, 5'd1, 16'h0040);
		rom[2] = iIns(LW, 5'd0, 5'd2, 16'h0040);
		rom[3] = iIns(XORI, 5'd0, 5'd3, 16'h0010);
		rom[4] = rIns(isaPkg::ADD, 5'd2, 5'd3, 5'd4);
		rom[5] = iIns(SW, 5'd0, 5'd4, 16'h0044);
		rom[6] = iIns(XORI, 5'd0, 5'd0, 16'h0077); // register zero stays 0
		rom[7] = iIns(SW, 5'd0, 5'd0, 16'h0048);
		rom[8] = iIns(XORI, 5'd0, 5'd5, 16'h0050);
		rom[9] = iIns(LW, 5'd5, 5'd6, 16'hfff0); // negative offset
		rom[10] = iIns(SW, 5'd5, 5'd6, 16'h0004);
		expQ.push_back(busOp(1'b1, 32'h40, 32'h5a5a));
		expQ.push_back(busOp(1'b0, 32'h40, 32'd0));
		expQ.push_back(busOp(1'b1, 32'h44, 32'h5a5a + 32'h10));
		expQ.push_back(busOp(1'b1, 32'h48, 32'd0));
		expQ.push_back(busOp(1'b0, 32'h40, 32'd0));
		expQ.push_back(busOp(1'b1, 32'h54, 32'h5a5a));
		pathRange(32'd0, 32'd44);
		runProgram();
	endtask

	task automatic branchPaths();
		holdReset("branch");
		rom[0] = iIns(XORI, 5'd0, 5'd1, 16'h0001);
		rom[1] = iIns(XORI, 5'd0, 5'd2, 16'h0002);
		rom[2] = iIns(BNE, 5'd1, 5'd2, 16'h0002); // taken to 20
		rom[3] = iIns(XORI, 5'd0, 5'd3, 16'h0033);
		rom[4] = iIns(XORI, 5'd0, 5'd3, 16'h0044);
		rom[5] = iIns(BNE, 5'd1, 5'd1, 16'h0003); // not taken
		rom[6] = iIns(XORI, 5'd0, 5'd4, 16'h0055);
		rom[7] = iIns(SW, 5'd0, 5'd3, 16'h0010);
		rom[8] = iIns(SW, 5'd0, 5'd4, 16'h0014);
		expQ.push_back(busOp(1'b1, 32'h10, 32'd0));
		expQ.push_back(busOp(1'b1, 32'h14, 32'h55));
		pathRange(32'd0, 32'd8);
		pathRange(32'd20, 32'd36);
		runProgram();
	endtask

	task automatic jumpTargets();
		holdReset("jumps");
		rom[0] = jIns(J, 32'd12);
		rom[1] = iIns(XORI, 5'd0, 5'd1, 16'h0011);
		rom[2] = iIns(XORI, 5'd0, 5'd1, 16'h0022);
		rom[3] = jIns(JAL, 32'd32);
		rom[4] = iIns(SW, 5'd0, 5'd1, 16'h0024);
		rom[8] = iIns(SW, 5'd0, RA_REG, 16'h0020);
		rom[9] = rIns(JR, RA_REG, 5'd0, 5'd0);
		expQ.push_back(busOp(1'b1, 32'h20, 32'd12 + 32'd4)); // link is pc + 4
		expQ.push_back(busOp(1'b1, 32'h24, 32'd0));
		pathRange(32'd0, 32'd0);
		pathRange(32'd12, 32'd12);
		pathRange(32'd32, 32'd36);
		pathRange(32'd16, 32'd20);
		runProgram();
	endtask

	task automatic undefinedCodes();
		holdReset("undefined");
		rom[0] = iIns(XORI, 5'd0, 5'd1, 16'h0099);
		rom[1] = iIns(6'h3f, 5'd1, 5'd1, 16'h0001);
		rom[2] = rIns(6'h3f, 5'd1, 5'd1, 5'd1);
		rom[3] = iIns(SW, 5'd0, 5'd1, 16'h0030);
		expQ.push_back(busOp(1'b1, 32'h30, 32'h99));
		pathRange(32'd0, 32'd16);
		runProgram();
	endtask

	// 6 tests, 64 instructions, 7 cycles, 8 ns
	initial begin
		#(6 * 64 * 7 * 8);
		stopFail("timeout: the tests did not finish in time");
	end

	initial begin
		for (int i = 0; i < 64; i++) begin
			slaveMem[i] = 32'hd00d0000 ^ word_t'(i * 32'h00010001);
			rom[i] = jIns(J, word_t'(i * 4));
		end
		resetValues();
		arithOps();
		loadStoreWaits();
		branchPaths();
		jumpTargets();
		undefinedCodes();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- tbMips_sva.sv
`timescale 1ns/10ps

module tbMips_sva
	import isaPkg::*, corePkg::*;
(
	input logic clk,
	input logic rstN,
	input word_t imemAddr,
	input wbMaster_t wbOut,
	input wbSlave_t wbIn
);

	cycIsStb: assert property (@(posedge clk) disable iff (!rstN) wbOut.cyc == wbOut.stb)
		else $error("cyc and stb differ");

	// request held until the slave acks
	reqStable: assert property (@(posedge clk) disable iff (!rstN)
		(wbOut.stb && !wbIn.ack) |=> ($stable(wbOut.adr) && $stable(wbOut.we)
		&& $stable(wbOut.datW)))
		else $error("adr, we or datW changed before ack");

	fetchAligned: assert property (@(posedge clk) disable iff (!rstN) imemAddr[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	idleAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !wbOut.cyc)
		else $error("bus cycle open right after reset");

endmodule

bind mipsCore tbMips_sva uSva (
	.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .wbOut(wbOut), .wbIn(wbIn)
);
